// ==== ahb_pkg.sv ====
// AHB-lite bus definitions shared by the slave port and the top level
// Bus widths
// Transfer type codes driven on htrans
// Response codes returned on hresp

`default_nettype none

package ahb_pkg;

    // --------------------------------------
    // Bus widths
    // --------------------------------------

    // Byte address bus
    localparam int HADDR_WIDTH = 32;
    // Read and write data buses
    localparam int HDATA_WIDTH = 32;

    // --------------------------------------
    // Transfer types (htrans)
    // --------------------------------------

    // No transfer wanted, slave answers OKAY
    localparam logic [1:0] TRANS_IDLE = 2'b00;
    // Master inserts a wait inside a burst
    localparam logic [1:0] TRANS_BUSY = 2'b01;
    // First beat of a burst or a single transfer
    localparam logic [1:0] TRANS_NONSEQ = 2'b10;
    // Following beats of a burst
    localparam logic [1:0] TRANS_SEQ = 2'b11;

    // --------------------------------------
    // Responses (hresp)
    // --------------------------------------

    // Transfer done or still in progress
    localparam logic [1:0] RESP_OKAY = 2'b00;
    // Transfer failed, always a two-cycle answer
    localparam logic [1:0] RESP_ERROR = 2'b01;

endpackage

`default_nettype wire

// ==== pmu_pkg.sv ====
// PMU register map definitions
// Register width
// Word indices of the fixed registers
// Bit positions inside the configuration register

`default_nettype none

package pmu_pkg;

    // --------------------------------------
    // Register geometry
    // --------------------------------------

    // Every register in the map is one bus word
    localparam int REG_WIDTH = 32;

    // --------------------------------------
    // Word indices
    // --------------------------------------

    // Configuration register sits at the bottom of the map
    localparam int CFG_INDEX = 0;
    // Counters follow it back to back
    // Status register comes right after the last counter
    localparam int COUNTER_BASE = 1;

    // --------------------------------------
    // Configuration bits
    // --------------------------------------

    // Global count enable, stored
    localparam int CFG_EN_BIT = 0;
    // Soft reset request, acts once and reads as zero
    localparam int CFG_SOFTRST_BIT = 1;

endpackage

`default_nettype wire

// ==== ahb_slave_port.sv ====
// AHB-lite slave front end of the PMU
// Address-phase capture into data-phase state
// Range check of the word index
// Two-cycle ERROR response FSM
// Read and write strobes toward the register map

`timescale 1ns/1ns
`default_nettype none

module ahb_slave_port #(
    // Number of words in the register map
    parameter int N_REGS = 26
) (
    input  wire                            clk_i,
    input  wire                            rstn_i,
    // Bus side
    input  wire                            hsel_i,
    input  wire                            hreadyi_i,
    input  wire [ahb_pkg::HADDR_WIDTH-1:0] haddr_i,
    input  wire                            hwrite_i,
    input  wire [1:0]                      htrans_i,
    input  wire [ahb_pkg::HDATA_WIDTH-1:0] hwdata_i,
    output logic                           hreadyo_o,
    output logic [1:0]                     hresp_o,
    output logic [ahb_pkg::HDATA_WIDTH-1:0] hrdata_o,
    // Register map side
    input  wire [ahb_pkg::HDATA_WIDTH-1:0] rdata_i,
    output logic                           wr_en_o,
    output logic                           rd_en_o,
    output logic [$clog2(N_REGS)-1:0]      idx_o,
    output logic [ahb_pkg::HDATA_WIDTH-1:0] wdata_o
);

    // Word index keeps every address bit above the byte offset
    localparam int WORD_W = ahb_pkg::HADDR_WIDTH - 2;
    localparam int IDX_WIDTH = $clog2(N_REGS);
    // First index outside the map
    localparam logic [WORD_W-1:0] IDX_LIMIT = WORD_W'(N_REGS);

    // Error FSM states
    localparam logic ST_OKAY = 1'b0;
    localparam logic ST_ERR_TAIL = 1'b1;

    logic              accept;
    logic              dp_active_q;
    logic              dp_write_q;
    logic [WORD_W-1:0] dp_idx_q;
    logic              in_range;
    logic              err_state_q;
    logic              err_start;

    // --------------------------------------
    // Address phase
    // --------------------------------------

    // Only NONSEQ and SEQ carry a transfer
    // IDLE and BUSY just get the default OKAY
    assign accept = hsel_i && hreadyi_i &&
                    ((htrans_i == ahb_pkg::TRANS_NONSEQ) ||
                     (htrans_i == ahb_pkg::TRANS_SEQ));

    // Data phase is live in the cycle after an accepted address phase
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            dp_active_q <= 1'b0;
        end else begin
            dp_active_q <= accept;
        end
    end

    // Direction and word index of the accepted transfer
    always_ff @(posedge clk_i) begin
        if (accept) begin
            dp_write_q <= hwrite_i;
            dp_idx_q   <= haddr_i[ahb_pkg::HADDR_WIDTH-1:2];
        end
    end

    // --------------------------------------
    // Data phase
    // --------------------------------------

    assign in_range = (dp_idx_q < IDX_LIMIT);

    // Out-of-range transfer opens the ERROR sequence
    // Guarded by the state so a stuck index cannot stall forever
    assign err_start = dp_active_q && !in_range && (err_state_q == ST_OKAY);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            err_state_q <= ST_OKAY;
        end else if (err_start) begin
            err_state_q <= ST_ERR_TAIL;
        end else begin
            err_state_q <= ST_OKAY;
        end
    end

    // First ERROR cycle stretches the transfer, second one ends it
    always_comb begin
        if (err_start) begin
            hreadyo_o = 1'b0;
            hresp_o   = ahb_pkg::RESP_ERROR;
        end else if (err_state_q == ST_ERR_TAIL) begin
            hreadyo_o = 1'b1;
            hresp_o   = ahb_pkg::RESP_ERROR;
        end else begin
            hreadyo_o = 1'b1;
            hresp_o   = ahb_pkg::RESP_OKAY;
        end
    end

    // Strobes toward the register map, only for in-range words
    assign wr_en_o = dp_active_q && dp_write_q && in_range;
    assign rd_en_o = dp_active_q && !dp_write_q && in_range;
    assign idx_o   = dp_idx_q[IDX_WIDTH-1:0];

    // Write data is valid on the bus during the data phase itself
    assign wdata_o = hwdata_i;

    // Idle, write and error cycles return zero
    assign hrdata_o = rd_en_o ? rdata_i : '0;

endmodule

`default_nettype wire

// ==== pmu_counters.sv ====
// PMU event counter bank
// One 32-bit counter per event input
// Wrap detection and sticky overflow status
// Registered overflow interrupt

`timescale 1ns/1ns
`default_nettype none

module pmu_counters #(
    parameter int N_COUNTERS = 24
) (
    input  wire                                  clk_i,
    input  wire                                  rstn_i,
    input  wire [N_COUNTERS-1:0]                 events_i,
    input  wire                                  count_en_i,
    input  wire                                  clear_i,
    input  wire                                  cnt_we_i,
    input  wire [((N_COUNTERS > 1) ? $clog2(N_COUNTERS) : 1)-1:0] cnt_sel_i,
    input  wire                                  st_we_i,
    input  wire [pmu_pkg::REG_WIDTH-1:0]         wdata_i,
    output logic [N_COUNTERS*pmu_pkg::REG_WIDTH-1:0] counters_o,
    output logic [N_COUNTERS-1:0]                status_o,
    output logic                                 intr_overflow_o
);

    localparam int SEL_WIDTH = (N_COUNTERS > 1) ? $clog2(N_COUNTERS) : 1;

    logic [pmu_pkg::REG_WIDTH-1:0] cnt_q [N_COUNTERS];
    logic [N_COUNTERS-1:0]         wrap;
    logic [N_COUNTERS-1:0]         status_d;
    logic [N_COUNTERS-1:0]         status_q;
    logic                          intr_q;

    // --------------------------------------
    // Counters
    // --------------------------------------

    for (genvar i = 0; i < N_COUNTERS; i++) begin : g_cnt
        logic inc;
        logic hit;

        // Enabled event in this cycle
        assign inc = count_en_i && events_i[i];
        // Bus write aimed at this counter
        assign hit = cnt_we_i && (cnt_sel_i == SEL_WIDTH'(i));

        // A bus write replaces the increment, so no wrap then
        assign wrap[i] = inc && !hit && (cnt_q[i] == '1);

        // Priority: soft reset, bus write, increment
        always_ff @(posedge clk_i or negedge rstn_i) begin
            if (!rstn_i) begin
                cnt_q[i] <= '0;
            end else if (clear_i) begin
                cnt_q[i] <= '0;
            end else if (hit) begin
                cnt_q[i] <= wdata_i;
            end else if (inc) begin
                cnt_q[i] <= cnt_q[i] + 1;
            end
        end

        assign counters_o[i*pmu_pkg::REG_WIDTH +: pmu_pkg::REG_WIDTH] = cnt_q[i];
    end

    // --------------------------------------
    // Overflow status
    // --------------------------------------

    // A wrap wins over a write-1-to-clear in the same cycle
    always_comb begin
        if (clear_i) begin
            status_d = '0;
        end else begin
            status_d = status_q;
            if (st_we_i) begin
                status_d = status_d & ~wdata_i[N_COUNTERS-1:0];
            end
            status_d = status_d | wrap;
        end
    end

    // Interrupt taken from the next status so it rises with the wrap
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            status_q <= '0;
            intr_q   <= 1'b0;
        end else begin
            status_q <= status_d;
            intr_q   <= |status_d;
        end
    end

    assign status_o        = status_q;
    assign intr_overflow_o = intr_q;

endmodule

`default_nettype wire

// ==== pmu_regmap.sv ====
// PMU register map
// Configuration register with count enable
// Self-clearing soft reset strobe
// Write decode into the counter bank
// Read data multiplexer

`timescale 1ns/1ns
`default_nettype none

module pmu_regmap #(
    parameter int N_COUNTERS = 24
) (
    input  wire                                 clk_i,
    input  wire                                 rstn_i,
    input  wire                                 wr_en_i,
    input  wire                                 rd_en_i,
    input  wire [$clog2(N_COUNTERS+2)-1:0]      idx_i,
    input  wire [ahb_pkg::HDATA_WIDTH-1:0]      wdata_i,
    input  wire [N_COUNTERS-1:0]                events_i,
    output logic [ahb_pkg::HDATA_WIDTH-1:0]     rdata_o,
    output logic                                intr_overflow_o
);

    // Map size follows the counter count
    localparam int N_REGS = N_COUNTERS + 2;
    localparam int IDX_WIDTH = $clog2(N_REGS);
    localparam int STATUS_INDEX = N_COUNTERS + 1;
    // Counter number needs at least one bit
    localparam int SEL_WIDTH = (N_COUNTERS > 1) ? $clog2(N_COUNTERS) : 1;

    logic                                   cfg_en_q;
    logic                                   cfg_we;
    logic                                   soft_clear;
    logic                                   cnt_we;
    logic                                   st_we;
    logic [IDX_WIDTH-1:0]                   cnt_offset;
    logic [SEL_WIDTH-1:0]                   cnt_sel;
    logic [N_COUNTERS*pmu_pkg::REG_WIDTH-1:0] counters;
    logic [N_COUNTERS-1:0]                  status;

    // --------------------------------------
    // Write decode
    // --------------------------------------

    assign cfg_we = wr_en_i && (idx_i == IDX_WIDTH'(pmu_pkg::CFG_INDEX));
    assign st_we  = wr_en_i && (idx_i == IDX_WIDTH'(STATUS_INDEX));
    assign cnt_we = wr_en_i &&
                    (idx_i >= IDX_WIDTH'(pmu_pkg::COUNTER_BASE)) &&
                    (idx_i <  IDX_WIDTH'(pmu_pkg::COUNTER_BASE + N_COUNTERS));

    // Counter number relative to the first counter word
    assign cnt_offset = idx_i - IDX_WIDTH'(pmu_pkg::COUNTER_BASE);
    assign cnt_sel    = cnt_offset[SEL_WIDTH-1:0];

    // Soft reset lives only for the write data phase
    // Counters see it at the edge that ends that phase
    assign soft_clear = cfg_we && wdata_i[pmu_pkg::CFG_SOFTRST_BIT];

    // --------------------------------------
    // Configuration register
    // --------------------------------------

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cfg_en_q <= 1'b0;
        end else if (cfg_we) begin
            cfg_en_q <= wdata_i[pmu_pkg::CFG_EN_BIT];
        end
    end

    // --------------------------------------
    // Counter bank
    // --------------------------------------

    pmu_counters #(
        .N_COUNTERS (N_COUNTERS)
    ) u_counters (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .events_i        (events_i),
        .count_en_i      (cfg_en_q),
        .clear_i         (soft_clear),
        .cnt_we_i        (cnt_we),
        .cnt_sel_i       (cnt_sel),
        .st_we_i         (st_we),
        .wdata_i         (wdata_i),
        .counters_o      (counters),
        .status_o        (status),
        .intr_overflow_o (intr_overflow_o)
    );

    // --------------------------------------
    // Read multiplexer
    // --------------------------------------

    // Unused config bits and the soft reset bit read as zero
    always_comb begin
        rdata_o = '0;
        if (rd_en_i) begin
            if (idx_i == IDX_WIDTH'(pmu_pkg::CFG_INDEX)) begin
                rdata_o[pmu_pkg::CFG_EN_BIT] = cfg_en_q;
            end else if (idx_i == IDX_WIDTH'(STATUS_INDEX)) begin
                rdata_o[N_COUNTERS-1:0] = status;
            end else begin
                // Remaining in-range words are counters
                rdata_o = counters[cnt_sel*pmu_pkg::REG_WIDTH +: pmu_pkg::REG_WIDTH];
            end
        end
    end

endmodule

`default_nettype wire

// ==== pmu_ahb.sv ====
// PMU top level with AHB-lite slave port
// Slave port instance handling bus phases and errors
// Register map instance holding config, counters and status

`timescale 1ns/1ns
`default_nettype none

module pmu_ahb #(
    // Number of event counters, 1 to 30
    parameter int N_COUNTERS = 24
) (
    input  wire                             clk_i,
    input  wire                             rstn_i,
    // AHB-lite slave
    input  wire                             hsel_i,
    input  wire                             hreadyi_i,
    input  wire [ahb_pkg::HADDR_WIDTH-1:0]  haddr_i,
    input  wire                             hwrite_i,
    input  wire [1:0]                       htrans_i,
    input  wire [ahb_pkg::HDATA_WIDTH-1:0]  hwdata_i,
    output wire                             hreadyo_o,
    output wire [1:0]                       hresp_o,
    output wire [ahb_pkg::HDATA_WIDTH-1:0]  hrdata_o,
    // Event inputs and overflow interrupt
    input  wire [N_COUNTERS-1:0]            events_i,
    output wire                             intr_overflow_o
);

    // Config word, counters, status word
    localparam int N_REGS = N_COUNTERS + 2;
    localparam int IDX_WIDTH = $clog2(N_REGS);

    // --------------------------------------
    // Internal strobes
    // --------------------------------------

    wire                            wr_en;
    wire                            rd_en;
    wire [IDX_WIDTH-1:0]            idx;
    wire [ahb_pkg::HDATA_WIDTH-1:0] wdata;
    wire [ahb_pkg::HDATA_WIDTH-1:0] rdata;

    // Bus protocol and range check
    ahb_slave_port #(
        .N_REGS (N_REGS)
    ) u_slave_port (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .hsel_i    (hsel_i),
        .hreadyi_i (hreadyi_i),
        .haddr_i   (haddr_i),
        .hwrite_i  (hwrite_i),
        .htrans_i  (htrans_i),
        .hwdata_i  (hwdata_i),
        .hreadyo_o (hreadyo_o),
        .hresp_o   (hresp_o),
        .hrdata_o  (hrdata_o),
        .rdata_i   (rdata),
        .wr_en_o   (wr_en),
        .rd_en_o   (rd_en),
        .idx_o     (idx),
        .wdata_o   (wdata)
    );

    // Registers and counter bank
    pmu_regmap #(
        .N_COUNTERS (N_COUNTERS)
    ) u_regmap (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .wr_en_i         (wr_en),
        .rd_en_i         (rd_en),
        .idx_i           (idx),
        .wdata_i         (wdata),
        .events_i        (events_i),
        .rdata_o         (rdata),
        .intr_overflow_o (intr_overflow_o)
    );

endmodule

`default_nettype wire

// ==== tb_pmu_ahb.sv ====
// Directed testbench for the AHB-lite PMU
// Bus read, write and error-access tasks with bounded waits
// Fibonacci LFSR for data and event patterns
// Value check task with error and check counters
// Tests for reset, read-back, counting, overflow, soft reset and ERROR

`timescale 1ns/1ns
`default_nettype none

module tb_pmu_ahb;

    localparam int N_COUNTERS = 24;
    localparam int N_REGS = N_COUNTERS + 2;
    localparam int STATUS_IDX = N_COUNTERS + 1;
    localparam int TIMEOUT_CYCLES = 16;
    localparam int COUNT_CYCLES = 40;
    localparam logic [31:0] CFG_EN_VAL = 32'd1 << pmu_pkg::CFG_EN_BIT;
    localparam logic [31:0] CFG_SOFTRST_VAL = 32'd1 << pmu_pkg::CFG_SOFTRST_BIT;

    logic                  clk_i;
    logic                  rstn_i;
    logic                  hsel_i;
    logic                  hreadyi_i;
    logic [31:0]           haddr_i;
    logic                  hwrite_i;
    logic [1:0]            htrans_i;
    logic [31:0]           hwdata_i;
    logic                  hreadyo_o;
    logic [1:0]            hresp_o;
    logic [31:0]           hrdata_o;
    logic [N_COUNTERS-1:0] events_i;
    logic                  intr_overflow_o;

    // Reference counter values, kept in step with every bus write and event
    logic [31:0] cnt_model [N_COUNTERS];
    logic [31:0] lfsr_q;
    int          err_cnt;
    int          check_cnt;

    pmu_ahb #(
        .N_COUNTERS (N_COUNTERS)
    ) dut (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .hsel_i          (hsel_i),
        .hreadyi_i       (hreadyi_i),
        .haddr_i         (haddr_i),
        .hwrite_i        (hwrite_i),
        .htrans_i        (htrans_i),
        .hwdata_i        (hwdata_i),
        .hreadyo_o       (hreadyo_o),
        .hresp_o         (hresp_o),
        .hrdata_o        (hrdata_o),
        .events_i        (events_i),
        .intr_overflow_o (intr_overflow_o)
    );

    // 20 ns clock
    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    // Taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] lfsr_word();
        logic [31:0] w;
        w = '0;
        for (int b = 0; b < 32; b++) begin
            w[b] = lfsr_bit();
        end
        return w;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERR t=%0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int start_err);
        if (err_cnt == start_err) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, err_cnt - start_err);
        end
    endtask

    // ----------------------------------------
    // Bus tasks
    // ----------------------------------------

    // One non-pipelined transfer, response sampled at the falling edges
    task automatic bus_transfer(input logic wr, input int idx, input logic [31:0] wdata,
                                output logic [31:0] rdata, output logic first_ready,
                                output logic [1:0] first_resp, output logic [1:0] last_resp,
                                output int waits);
        @(posedge clk_i);
        hsel_i   <= 1'b1;
        htrans_i <= ahb_pkg::TRANS_NONSEQ;
        haddr_i  <= 32'(idx) << 2;
        hwrite_i <= wr;
        // Address phase taken here, write data follows
        @(posedge clk_i);
        hsel_i   <= 1'b0;
        htrans_i <= ahb_pkg::TRANS_IDLE;
        hwdata_i <= wdata;
        @(negedge clk_i);
        first_ready = hreadyo_o;
        first_resp  = hresp_o;
        waits = 0;
        while (!hreadyo_o && waits < TIMEOUT_CYCLES) begin
            @(negedge clk_i);
            waits++;
        end
        if (!hreadyo_o) begin
            err_cnt++;
            $display("Timeout at %0t: hreadyo_o stayed low for %0d cycles, index %0d",
                     $time, waits, idx);
        end
        last_resp = hresp_o;
        rdata     = hrdata_o;
    endtask

    task automatic ahb_write(input int idx, input logic [31:0] data);
        logic [31:0] rdata;
        logic        first_ready;
        logic [1:0]  first_resp;
        logic [1:0]  last_resp;
        int          waits;
        bus_transfer(1'b1, idx, data, rdata, first_ready, first_resp, last_resp, waits);
        check("hreadyo_o on write", 32'(first_ready), 32'd1);
        check("hresp_o on write", 32'(last_resp), 32'(ahb_pkg::RESP_OKAY));
    endtask

    task automatic ahb_read(input int idx, output logic [31:0] data);
        logic        first_ready;
        logic [1:0]  first_resp;
        logic [1:0]  last_resp;
        int          waits;
        bus_transfer(1'b0, idx, 32'd0, data, first_ready, first_resp, last_resp, waits);
        check("hreadyo_o on read", 32'(first_ready), 32'd1);
        check("hresp_o on read", 32'(last_resp), 32'(ahb_pkg::RESP_OKAY));
    endtask

    // Out-of-map access, two-cycle ERROR expected
    task automatic expect_error_response(input logic wr, input int idx, input logic [31:0] data);
        logic [31:0] rdata;
        logic        first_ready;
        logic [1:0]  first_resp;
        logic [1:0]  last_resp;
        int          waits;
        bus_transfer(wr, idx, data, rdata, first_ready, first_resp, last_resp, waits);
        check("hreadyo_o first error cycle", 32'(first_ready), 32'd0);
        check("hresp_o first error cycle", 32'(first_resp), 32'(ahb_pkg::RESP_ERROR));
        check("hresp_o last error cycle", 32'(last_resp), 32'(ahb_pkg::RESP_ERROR));
        check("error wait cycles", 32'(waits), 32'd1);
        check("hrdata_o on error", rdata, 32'd0);
    endtask

    task automatic read_and_check(input int idx, input logic [31:0] exp);
        logic [31:0] data;
        ahb_read(idx, data);
        check($sformatf("reg[%0d]", idx), data, exp);
    endtask

    // Counter c to all-ones, one enabled event, counting off again
    task automatic force_overflow(input int c);
        logic [N_COUNTERS-1:0] one_hot;
        one_hot    = '0;
        one_hot[c] = 1'b1;
        ahb_write(pmu_pkg::COUNTER_BASE + c, 32'hffff_ffff);
        ahb_write(pmu_pkg::CFG_INDEX, CFG_EN_VAL);
        @(posedge clk_i);
        events_i <= one_hot;
        @(posedge clk_i);
        events_i <= '0;
        ahb_write(pmu_pkg::CFG_INDEX, 32'd0);
        cnt_model[c] = 32'd0;
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------

    task automatic test_reset_state();
        int start_err;
        start_err = err_cnt;
        @(negedge clk_i);
        check("hreadyo_o", 32'(hreadyo_o), 32'd1);
        check("hresp_o", 32'(hresp_o), 32'(ahb_pkg::RESP_OKAY));
        check("intr_overflow_o", 32'(intr_overflow_o), 32'd0);
        for (int r = 0; r < N_REGS; r++) begin
            read_and_check(r, 32'd0);
        end
        report_test("reset_state", start_err);
    endtask

    task automatic test_register_readback();
        int start_err;
        start_err = err_cnt;
        for (int c = 0; c < N_COUNTERS; c++) begin
            cnt_model[c] = lfsr_word();
            ahb_write(pmu_pkg::COUNTER_BASE + c, cnt_model[c]);
        end
        for (int c = 0; c < N_COUNTERS; c++) begin
            read_and_check(pmu_pkg::COUNTER_BASE + c, cnt_model[c]);
        end
        // Soft reset bit reads back clear, enable bit stays
        ahb_write(pmu_pkg::CFG_INDEX, CFG_EN_VAL | CFG_SOFTRST_VAL);
        for (int c = 0; c < N_COUNTERS; c++) begin
            cnt_model[c] = 32'd0;
        end
        read_and_check(pmu_pkg::CFG_INDEX, CFG_EN_VAL);
        ahb_write(pmu_pkg::CFG_INDEX, 32'd0);
        report_test("register_readback", start_err);
    endtask

    task automatic test_counting();
        int                    start_err;
        logic [N_COUNTERS-1:0] pattern;
        start_err = err_cnt;
        // Top bit clear so nothing wraps here
        for (int c = 0; c < N_COUNTERS; c++) begin
            cnt_model[c] = lfsr_word() >> 1;
            ahb_write(pmu_pkg::COUNTER_BASE + c, cnt_model[c]);
        end
        ahb_write(pmu_pkg::CFG_INDEX, CFG_EN_VAL);
        for (int k = 0; k < COUNT_CYCLES; k++) begin
            @(posedge clk_i);
            for (int c = 0; c < N_COUNTERS; c++) begin
                pattern[c] = lfsr_bit();
                if (pattern[c]) begin
                    cnt_model[c] = cnt_model[c] + 32'd1;
                end
            end
            events_i <= pattern;
        end
        @(posedge clk_i);
        events_i <= '0;
        ahb_write(pmu_pkg::CFG_INDEX, 32'd0);
        for (int c = 0; c < N_COUNTERS; c++) begin
            read_and_check(pmu_pkg::COUNTER_BASE + c, cnt_model[c]);
        end
        read_and_check(STATUS_IDX, 32'd0);
        report_test("counting", start_err);
    endtask

    task automatic test_overflow();
        int          start_err;
        int          c;
        logic [31:0] bit_c;
        start_err = err_cnt;
        c     = 7;
        bit_c = 32'd1 << c;
        force_overflow(c);
        @(negedge clk_i);
        check("intr_overflow_o after wrap", 32'(intr_overflow_o), 32'd1);
        for (int i = 0; i < N_COUNTERS; i++) begin
            read_and_check(pmu_pkg::COUNTER_BASE + i, cnt_model[i]);
        end
        read_and_check(STATUS_IDX, bit_c);
        // Write-1-to-clear on the status bit
        ahb_write(STATUS_IDX, bit_c);
        read_and_check(STATUS_IDX, 32'd0);
        @(negedge clk_i);
        check("intr_overflow_o after clear", 32'(intr_overflow_o), 32'd0);
        report_test("overflow", start_err);
    endtask

    task automatic test_soft_reset();
        int start_err;
        start_err = err_cnt;
        force_overflow(3);
        @(negedge clk_i);
        check("intr_overflow_o before soft reset", 32'(intr_overflow_o), 32'd1);
        ahb_write(pmu_pkg::CFG_INDEX, CFG_SOFTRST_VAL);
        for (int r = 0; r < N_REGS; r++) begin
            read_and_check(r, 32'd0);
        end
        @(negedge clk_i);
        check("intr_overflow_o after soft reset", 32'(intr_overflow_o), 32'd0);
        for (int c = 0; c < N_COUNTERS; c++) begin
            cnt_model[c] = 32'd0;
        end
        report_test("soft_reset", start_err);
    endtask

    task automatic test_error_response();
        int start_err;
        start_err = err_cnt;
        for (int c = 0; c < N_COUNTERS; c++) begin
            cnt_model[c] = lfsr_word();
            ahb_write(pmu_pkg::COUNTER_BASE + c, cnt_model[c]);
        end
        expect_error_response(1'b0, N_REGS, 32'd0);
        // Index 33 would alias counter 0 if the range check dropped high bits
        expect_error_response(1'b1, 33, lfsr_word());
        expect_error_response(1'b1, N_REGS, 32'hffff_ffff);
        // Configuration and status stay clear since the soft reset
        read_and_check(pmu_pkg::CFG_INDEX, 32'd0);
        for (int c = 0; c < N_COUNTERS; c++) begin
            read_and_check(pmu_pkg::COUNTER_BASE + c, cnt_model[c]);
        end
        read_and_check(STATUS_IDX, 32'd0);
        report_test("error_response", start_err);
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        rstn_i    = 1'b0;
        hsel_i    = 1'b0;
        hreadyi_i = 1'b1;
        haddr_i   = '0;
        hwrite_i  = 1'b0;
        htrans_i  = ahb_pkg::TRANS_IDLE;
        hwdata_i  = '0;
        events_i  = '0;
        lfsr_q    = 32'h68a3943f;
        err_cnt   = 0;
        check_cnt = 0;
        repeat (10) @(posedge clk_i);
        rstn_i <= 1'b1;

        test_reset_state();
        test_register_readback();
        test_counting();
        test_overflow();
        test_soft_reset();
        test_error_response();

        $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
ahb_pkg.sv
pmu_pkg.sv
ahb_slave_port.sv
pmu_counters.sv
pmu_regmap.sv
pmu_ahb.sv
tb_pmu_ahb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the PMU testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -f src.f --top-module tb_pmu_ahb -Mdir "$OBJ" -o Vtb_pmu_ahb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/Vtb_pmu_ahb" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "^Testbench passed$" "$LOG"; then
    echo "Result: pass"
    exit 0
else
    echo "Result: fail"
    exit 1
fi
